//--- include/commit_defs.svh
`ifndef COMMIT_DEFS_SVH
`define COMMIT_DEFS_SVH

// instruction address width
`define COMMIT_PC_W 32
// physical destination register pointer
`define COMMIT_PREG_W 6
// logical destination register pointer
`define COMMIT_LREG_W 5
// flag physical register pointer
`define COMMIT_FPREG_W 4
// address distance between the two dispatch slots
`define COMMIT_PC_STEP 4

`endif

//--- design/commit_pkg.sv
package commit_pkg;

`include "commit_defs.svh"

	localparam int PC_W = `COMMIT_PC_W;
	localparam int PREG_W = `COMMIT_PREG_W;
	localparam int LREG_W = `COMMIT_LREG_W;
	localparam int FPREG_W = `COMMIT_FPREG_W;

	// slot 1 sits one instruction after slot 0
	localparam logic [PC_W-1:0] PC_STEP = PC_W'(`COMMIT_PC_STEP);

endpackage

//--- design/commit_regist.sv
`timescale 1ns/1ps

module commit_regist
	import commit_pkg::*;
#(
	parameter int ENTRIES = 16,
	localparam int TAG_W = $clog2(ENTRIES)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input logic d0_valid,
	input logic d0_make_flags,
	input logic d0_writeback,
	input logic [FPREG_W-1:0] d0_flags_preg,
	input logic [PREG_W-1:0] d0_dest_preg,
	input logic [LREG_W-1:0] d0_dest_lreg,
	input logic d0_dest_sysreg,
	input logic d0_ex_branch,
	input logic d1_valid,
	input logic d1_make_flags,
	input logic d1_writeback,
	input logic [FPREG_W-1:0] d1_flags_preg,
	input logic [PREG_W-1:0] d1_dest_preg,
	input logic [LREG_W-1:0] d1_dest_lreg,
	input logic d1_dest_sysreg,
	input logic d1_ex_branch,
	input logic [PC_W-1:0] pc,
	input logic retire_pulse,
	output logic stall,
	output logic [TAG_W-1:0] regist_tag0,
	output logic [TAG_W-1:0] regist_tag1,
	output logic r_valid0,
	output logic r_make_flags0,
	output logic r_writeback0,
	output logic [FPREG_W-1:0] r_flags_preg0,
	output logic [PREG_W-1:0] r_dest_preg0,
	output logic [LREG_W-1:0] r_dest_lreg0,
	output logic r_dest_sysreg0,
	output logic r_ex_branch0,
	output logic r_valid1,
	output logic r_make_flags1,
	output logic r_writeback1,
	output logic [FPREG_W-1:0] r_flags_preg1,
	output logic [PREG_W-1:0] r_dest_preg1,
	output logic [LREG_W-1:0] r_dest_lreg1,
	output logic r_dest_sysreg1,
	output logic r_ex_branch1,
	output logic [PC_W-1:0] r_pc,
	output logic [TAG_W-1:0] r_base
);

	localparam int CNT_W = TAG_W + 1;

	logic [TAG_W-1:0] tail;
	logic [CNT_W-1:0] count;	// entries held, including the two registration slots
	logic acc0;
	logic acc1;
	logic [1:0] acc_num;

	assign acc0 = d0_valid && !stall;
	assign acc1 = d1_valid && acc0;	// slot 1 only rides along with slot 0
	assign acc_num = {1'b0, acc0} + {1'b0, acc1};
	assign stall = count > CNT_W'(ENTRIES - 2);	// no room left for a full pair
	assign regist_tag0 = tail;
	assign regist_tag1 = tail + 1'b1;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tail <= '0;
			count <= '0;
			r_valid0 <= 1'b0;
			r_valid1 <= 1'b0;
			r_base <= '0;
		end else if (restart) begin
			tail <= '0;
			count <= '0;
			r_valid0 <= 1'b0;
			r_valid1 <= 1'b0;
			r_base <= '0;
		end else begin
			tail <= tail + TAG_W'(acc_num);
			count <= count + CNT_W'(acc_num) - CNT_W'(retire_pulse);
			r_valid0 <= acc0;
			r_valid1 <= acc1;
			r_base <= tail;	// the entries pick their slot against this pointer
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (acc0) begin
			r_pc <= pc;
			r_make_flags0 <= d0_make_flags;
			r_writeback0 <= d0_writeback;
			r_flags_preg0 <= d0_flags_preg;
			r_dest_preg0 <= d0_dest_preg;
			r_dest_lreg0 <= d0_dest_lreg;
			r_dest_sysreg0 <= d0_dest_sysreg;
			r_ex_branch0 <= d0_ex_branch;
		end
		if (acc1) begin
			r_make_flags1 <= d1_make_flags;
			r_writeback1 <= d1_writeback;
			r_flags_preg1 <= d1_flags_preg;
			r_dest_preg1 <= d1_dest_preg;
			r_dest_lreg1 <= d1_dest_lreg;
			r_dest_sysreg1 <= d1_dest_sysreg;
			r_ex_branch1 <= d1_ex_branch;
		end
	end

endmodule

//--- design/commit_entry.sv
`timescale 1ns/1ps

module commit_entry
	import commit_pkg::*;
#(
	parameter int ENTRIES = 16,
	parameter int ENTRY_ID = 0,
	localparam int TAG_W = $clog2(ENTRIES)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input logic r_valid0,
	input logic r_valid1,
	input logic [TAG_W-1:0] r_base,
	input logic [PC_W-1:0] r_pc,
	input logic r_make_flags0,
	input logic r_writeback0,
	input logic [FPREG_W-1:0] r_flags_preg0,
	input logic [PREG_W-1:0] r_dest_preg0,
	input logic [LREG_W-1:0] r_dest_lreg0,
	input logic r_dest_sysreg0,
	input logic r_ex_branch0,
	input logic r_make_flags1,
	input logic r_writeback1,
	input logic [FPREG_W-1:0] r_flags_preg1,
	input logic [PREG_W-1:0] r_dest_preg1,
	input logic [LREG_W-1:0] r_dest_lreg1,
	input logic r_dest_sysreg1,
	input logic r_ex_branch1,
	input logic exend0_valid,
	input logic [TAG_W-1:0] exend0_tag,
	input logic exend1_valid,
	input logic [TAG_W-1:0] exend1_tag,
	input logic exend2_valid,
	input logic [TAG_W-1:0] exend2_tag,
	input logic exend3_valid,
	input logic [TAG_W-1:0] exend3_tag,
	input logic commit_strobe,
	output logic info_valid,
	output logic info_ex_end,
	output logic info_free,
	output logic [PC_W-1:0] info_pc,
	output logic info_make_flags,
	output logic info_writeback,
	output logic [FPREG_W-1:0] info_flags_preg,
	output logic [PREG_W-1:0] info_dest_preg,
	output logic [LREG_W-1:0] info_dest_lreg,
	output logic info_dest_sysreg,
	output logic info_ex_branch
);

	localparam logic [1:0] ST_FREE = 2'd0;
	localparam logic [1:0] ST_WAIT = 2'd1;
	localparam logic [1:0] ST_END = 2'd2;
	localparam logic [TAG_W-1:0] MY_TAG = TAG_W'(ENTRY_ID);

	logic [1:0] state;
	logic [TAG_W-1:0] base1;
	logic hit0;
	logic hit1;
	logic done;

	assign base1 = r_base + 1'b1;	// wraps around the ring
	assign hit0 = r_valid0 && (r_base == MY_TAG);
	assign hit1 = r_valid1 && (base1 == MY_TAG);
	assign done = (exend0_valid && exend0_tag == MY_TAG)
		|| (exend1_valid && exend1_tag == MY_TAG)
		|| (exend2_valid && exend2_tag == MY_TAG)
		|| (exend3_valid && exend3_tag == MY_TAG);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_FREE;
		end else if (restart) begin
			state <= ST_FREE;
		end else begin
			case (state)
				ST_FREE: if (hit0 || hit1) state <= ST_WAIT;
				ST_WAIT: if (done) state <= ST_END;	// any of the four units may finish it
				ST_END: if (commit_strobe) state <= ST_FREE;
				default: state <= ST_FREE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (state == ST_FREE) begin
			if (hit0) begin
				info_pc <= r_pc;
				info_make_flags <= r_make_flags0;
				info_writeback <= r_writeback0;
				info_flags_preg <= r_flags_preg0;
				info_dest_preg <= r_dest_preg0;
				info_dest_lreg <= r_dest_lreg0;
				info_dest_sysreg <= r_dest_sysreg0;
				info_ex_branch <= r_ex_branch0;
			end else if (hit1) begin
				info_pc <= r_pc + PC_STEP;	// slot 1 follows slot 0 in memory
				info_make_flags <= r_make_flags1;
				info_writeback <= r_writeback1;
				info_flags_preg <= r_flags_preg1;
				info_dest_preg <= r_dest_preg1;
				info_dest_lreg <= r_dest_lreg1;
				info_dest_sysreg <= r_dest_sysreg1;
				info_ex_branch <= r_ex_branch1;
			end
		end
	end

	assign info_valid = (state == ST_WAIT) || (state == ST_END);
	assign info_ex_end = (state == ST_END);
	assign info_free = restart && info_valid;	// marks an entry thrown away by the restart

endmodule

//--- design/commit_array.sv
`timescale 1ns/1ps

module commit_array
	import commit_pkg::*;
#(
	parameter int ENTRIES = 16,
	localparam int TAG_W = $clog2(ENTRIES)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input logic r_valid0,
	input logic r_valid1,
	input logic [TAG_W-1:0] r_base,
	input logic [PC_W-1:0] r_pc,
	input logic r_make_flags0,
	input logic r_writeback0,
	input logic [FPREG_W-1:0] r_flags_preg0,
	input logic [PREG_W-1:0] r_dest_preg0,
	input logic [LREG_W-1:0] r_dest_lreg0,
	input logic r_dest_sysreg0,
	input logic r_ex_branch0,
	input logic r_make_flags1,
	input logic r_writeback1,
	input logic [FPREG_W-1:0] r_flags_preg1,
	input logic [PREG_W-1:0] r_dest_preg1,
	input logic [LREG_W-1:0] r_dest_lreg1,
	input logic r_dest_sysreg1,
	input logic r_ex_branch1,
	input logic exend0_valid,
	input logic [TAG_W-1:0] exend0_tag,
	input logic exend1_valid,
	input logic [TAG_W-1:0] exend1_tag,
	input logic exend2_valid,
	input logic [TAG_W-1:0] exend2_tag,
	input logic exend3_valid,
	input logic [TAG_W-1:0] exend3_tag,
	input logic retire_pulse,
	input logic [TAG_W-1:0] head_tag,
	output logic head_valid,
	output logic head_ex_end,
	output logic [PC_W-1:0] head_pc,
	output logic head_make_flags,
	output logic head_writeback,
	output logic [FPREG_W-1:0] head_flags_preg,
	output logic [PREG_W-1:0] head_dest_preg,
	output logic [LREG_W-1:0] head_dest_lreg,
	output logic head_dest_sysreg,
	output logic head_ex_branch,
	output logic [TAG_W:0] flush_count
);

	logic [ENTRIES-1:0] info_valid;
	logic [ENTRIES-1:0] info_ex_end;
	logic [ENTRIES-1:0] info_free;
	logic [ENTRIES-1:0] info_make_flags;
	logic [ENTRIES-1:0] info_writeback;
	logic [ENTRIES-1:0] info_dest_sysreg;
	logic [ENTRIES-1:0] info_ex_branch;
	logic [PC_W-1:0] info_pc [ENTRIES];
	logic [FPREG_W-1:0] info_flags_preg [ENTRIES];
	logic [PREG_W-1:0] info_dest_preg [ENTRIES];
	logic [LREG_W-1:0] info_dest_lreg [ENTRIES];

	for (genvar i = 0; i < ENTRIES; i++) begin : g_entry
		commit_entry #(
			.ENTRIES(ENTRIES),
			.ENTRY_ID(i)
		) u_entry (
			.iCLOCK, .inRESET, .restart,
			.r_valid0, .r_valid1, .r_base, .r_pc,
			.r_make_flags0, .r_writeback0, .r_flags_preg0, .r_dest_preg0,
			.r_dest_lreg0, .r_dest_sysreg0, .r_ex_branch0,
			.r_make_flags1, .r_writeback1, .r_flags_preg1, .r_dest_preg1,
			.r_dest_lreg1, .r_dest_sysreg1, .r_ex_branch1,
			.exend0_valid, .exend0_tag, .exend1_valid, .exend1_tag,
			.exend2_valid, .exend2_tag, .exend3_valid, .exend3_tag,
			.commit_strobe(retire_pulse && (head_tag == TAG_W'(i))),
			.info_valid(info_valid[i]),
			.info_ex_end(info_ex_end[i]),
			.info_free(info_free[i]),
			.info_pc(info_pc[i]),
			.info_make_flags(info_make_flags[i]),
			.info_writeback(info_writeback[i]),
			.info_flags_preg(info_flags_preg[i]),
			.info_dest_preg(info_dest_preg[i]),
			.info_dest_lreg(info_dest_lreg[i]),
			.info_dest_sysreg(info_dest_sysreg[i]),
			.info_ex_branch(info_ex_branch[i])
		);
	end

	assign head_valid = info_valid[head_tag];
	assign head_ex_end = info_ex_end[head_tag];
	assign head_pc = info_pc[head_tag];
	assign head_make_flags = info_make_flags[head_tag];
	assign head_writeback = info_writeback[head_tag];
	assign head_flags_preg = info_flags_preg[head_tag];
	assign head_dest_preg = info_dest_preg[head_tag];
	assign head_dest_lreg = info_dest_lreg[head_tag];
	assign head_dest_sysreg = info_dest_sysreg[head_tag];
	assign head_ex_branch = info_ex_branch[head_tag];

	// population count of the entries dropped this cycle
	always_comb begin
		flush_count = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			flush_count = flush_count + (TAG_W + 1)'(info_free[i]);
		end
	end

endmodule

//--- design/commit_retire.sv
`timescale 1ns/1ps

module commit_retire
	import commit_pkg::*;
#(
	parameter int ENTRIES = 16,
	localparam int TAG_W = $clog2(ENTRIES)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input logic head_valid,
	input logic head_ex_end,
	input logic [PC_W-1:0] head_pc,
	input logic head_make_flags,
	input logic head_writeback,
	input logic [FPREG_W-1:0] head_flags_preg,
	input logic [PREG_W-1:0] head_dest_preg,
	input logic [LREG_W-1:0] head_dest_lreg,
	input logic head_dest_sysreg,
	input logic head_ex_branch,
	output logic retire_pulse,
	output logic [TAG_W-1:0] head_tag,
	output logic commit_valid,
	output logic [PC_W-1:0] commit_pc,
	output logic commit_writeback,
	output logic commit_make_flags,
	output logic [FPREG_W-1:0] commit_flags_preg,
	output logic [PREG_W-1:0] commit_dest_preg,
	output logic [LREG_W-1:0] commit_dest_lreg,
	output logic commit_dest_sysreg,
	output logic commit_ex_branch
);

	// the oldest entry leaves as soon as it has finished, unless a restart drops it
	assign retire_pulse = head_valid && head_ex_end && !restart;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			head_tag <= '0;
			commit_valid <= 1'b0;
		end else if (restart) begin
			head_tag <= '0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire_pulse;
			if (retire_pulse) begin
				head_tag <= head_tag + 1'b1;	// wraps with the entry ring
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (retire_pulse) begin
			commit_pc <= head_pc;
			commit_writeback <= head_writeback;
			commit_make_flags <= head_make_flags;
			commit_flags_preg <= head_flags_preg;
			commit_dest_preg <= head_dest_preg;
			commit_dest_lreg <= head_dest_lreg;
			commit_dest_sysreg <= head_dest_sysreg;
			commit_ex_branch <= head_ex_branch;
		end
	end

endmodule

//--- design/commit_queue.sv
`timescale 1ns/1ps

module commit_queue
	import commit_pkg::*;
#(
	parameter int ENTRIES = 16,
	localparam int TAG_W = $clog2(ENTRIES)
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input logic d0_valid, d0_make_flags, d0_writeback,
	input logic [FPREG_W-1:0] d0_flags_preg,
	input logic [PREG_W-1:0] d0_dest_preg,
	input logic [LREG_W-1:0] d0_dest_lreg,
	input logic d0_dest_sysreg, d0_ex_branch,
	input logic d1_valid, d1_make_flags, d1_writeback,
	input logic [FPREG_W-1:0] d1_flags_preg,
	input logic [PREG_W-1:0] d1_dest_preg,
	input logic [LREG_W-1:0] d1_dest_lreg,
	input logic d1_dest_sysreg, d1_ex_branch,
	input logic [PC_W-1:0] pc,
	input logic exend0_valid, exend1_valid, exend2_valid, exend3_valid,
	input logic [TAG_W-1:0] exend0_tag, exend1_tag, exend2_tag, exend3_tag,
	output logic stall,
	output logic [TAG_W-1:0] regist_tag0, regist_tag1,
	output logic commit_valid,
	output logic [PC_W-1:0] commit_pc,
	output logic commit_writeback, commit_make_flags,
	output logic [FPREG_W-1:0] commit_flags_preg,
	output logic [PREG_W-1:0] commit_dest_preg,
	output logic [LREG_W-1:0] commit_dest_lreg,
	output logic commit_dest_sysreg, commit_ex_branch,
	output logic [TAG_W:0] flush_count
);

	logic r_valid0, r_make_flags0, r_writeback0, r_dest_sysreg0, r_ex_branch0;
	logic r_valid1, r_make_flags1, r_writeback1, r_dest_sysreg1, r_ex_branch1;
	logic [FPREG_W-1:0] r_flags_preg0, r_flags_preg1;
	logic [PREG_W-1:0] r_dest_preg0, r_dest_preg1;
	logic [LREG_W-1:0] r_dest_lreg0, r_dest_lreg1;
	logic [PC_W-1:0] r_pc, head_pc;
	logic [TAG_W-1:0] r_base, head_tag;
	logic head_valid, head_ex_end, head_make_flags, head_writeback;
	logic head_dest_sysreg, head_ex_branch, retire_pulse;
	logic [FPREG_W-1:0] head_flags_preg;
	logic [PREG_W-1:0] head_dest_preg;
	logic [LREG_W-1:0] head_dest_lreg;

	// dispatch is registered one cycle before the entries see it
	commit_regist #(.ENTRIES(ENTRIES)) u_regist (.*);

	commit_array #(.ENTRIES(ENTRIES)) u_array (.*);

	// in-order retire from the head of the ring
	commit_retire #(.ENTRIES(ENTRIES)) u_retire (.*);

endmodule

//--- sim/commit_queue_assertions.sv
`timescale 1ns/1ps

module commit_queue_assertions (
	input logic iCLOCK,
	input logic inRESET,
	input logic restart,
	input logic retire_pulse,
	input logic head_ex_end,
	input logic commit_valid
);

	ended_before_retire: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		retire_pulse |-> head_ex_end)
		else $error("retire_pulse while the head entry has not ended");

	commit_after_retire: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		retire_pulse |=> commit_valid)
		else $error("commit_valid missing one cycle after retire_pulse");

	quiet_after_restart: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		restart |=> !commit_valid)
		else $error("commit_valid high in the cycle after restart");

endmodule

bind commit_retire commit_queue_assertions u_assertions (
	.iCLOCK, .inRESET, .restart, .retire_pulse, .head_ex_end, .commit_valid
);

//--- sim/commit_queue_tb.sv
`timescale 1ns/1ps
`include "commit_defs.svh"

module commit_queue_tb;

	localparam int ENTRIES = 8;
	localparam int TAG_W = 3;
	localparam int F_W = 4 + `COMMIT_FPREG_W + `COMMIT_PREG_W + `COMMIT_LREG_W;

	typedef struct {
		bit rst, wt, v0, v1;	// wt drains the queue before the row is applied
		logic [`COMMIT_PC_W-1:0] pc;
		logic [F_W-1:0] f0, f1;
		int dl0, dl1;
	} row_t;
	typedef struct {
		logic [`COMMIT_PC_W-1:0] pc;
		logic [F_W-1:0] f;
		logic [TAG_W-1:0] tag;
		int acc;
	} ent_t;
	typedef struct {
		logic [TAG_W-1:0] tag;
		int due;
	} cmp_t;

	logic iCLOCK, inRESET, restart;
	logic d0_valid, d0_make_flags, d0_writeback, d0_dest_sysreg, d0_ex_branch;
	logic d1_valid, d1_make_flags, d1_writeback, d1_dest_sysreg, d1_ex_branch;
	logic [`COMMIT_FPREG_W-1:0] d0_flags_preg, d1_flags_preg, commit_flags_preg;
	logic [`COMMIT_PREG_W-1:0] d0_dest_preg, d1_dest_preg, commit_dest_preg;
	logic [`COMMIT_LREG_W-1:0] d0_dest_lreg, d1_dest_lreg, commit_dest_lreg;
	logic [`COMMIT_PC_W-1:0] pc, commit_pc;
	logic ex_v [4];
	logic [TAG_W-1:0] ex_t [4];
	logic stall, commit_valid, commit_writeback, commit_make_flags;
	logic commit_dest_sysreg, commit_ex_branch;
	logic [TAG_W-1:0] regist_tag0, regist_tag1, tag_m;
	logic [TAG_W:0] flush_count;

	row_t rows[$];
	ent_t mq[$];	// accepted instructions not yet committed
	cmp_t pend[$];
	int done_at [ENTRIES];	// cycle the completion strobe was driven, per tag
	int cyc = 0;
	int limit = 1000000;
	int last_c = 0;
	int stalls = 0;
	int val_errs = 0;
	int other_errs = 0;

	commit_queue #(.ENTRIES(ENTRIES)) i_dut (
		.*,
		.exend0_valid(ex_v[0]), .exend0_tag(ex_t[0]),
		.exend1_valid(ex_v[1]), .exend1_tag(ex_t[1]),
		.exend2_valid(ex_v[2]), .exend2_tag(ex_t[2]),
		.exend3_valid(ex_v[3]), .exend3_tag(ex_t[3])
	);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	initial begin
		wait (cyc > limit);
		$display("run stopped, no finish within %0d cycles", limit);
		$display("Verification failed");
		$finish;
	end

	task automatic add_row(input bit rst, wt, v0, v1, input logic [`COMMIT_PC_W-1:0] a,
			input logic [F_W-1:0] f0, f1, input int dl0, dl1);
		rows.push_back(row_t'{rst, wt, v0, v1, a, f0, f1, dl0, dl1});
	endtask

	task automatic flag_value(input string name, input logic [31:0] exp, got);
		$display("ERR %s cycle %0d exp %h got %h", name, cyc, exp, got);
		val_errs++;
	endtask

	task automatic clear_inputs();
		restart = 1'b0;
		pc = '0;
		d0_valid = 1'b0;
		d1_valid = 1'b0;
		{d0_make_flags, d0_writeback, d0_flags_preg, d0_dest_preg} = '0;
		{d0_dest_lreg, d0_dest_sysreg, d0_ex_branch} = '0;
		{d1_make_flags, d1_writeback, d1_flags_preg, d1_dest_preg} = '0;
		{d1_dest_lreg, d1_dest_sysreg, d1_ex_branch} = '0;
		for (int i = 0; i < 4; i++) begin
			ex_v[i] = 1'b0;
			ex_t[i] = '0;
		end
	endtask

	task automatic check_outputs();
		logic exp_cv;
		logic [F_W-1:0] got_f;
		logic [TAG_W-1:0] tag_n;
		int rdy;
		got_f = {commit_make_flags, commit_writeback, commit_flags_preg, commit_dest_preg,
			commit_dest_lreg, commit_dest_sysreg, commit_ex_branch};
		exp_cv = 1'b0;
		if (mq.size() > 0 && done_at[mq[0].tag] >= 0) begin
			rdy = done_at[mq[0].tag] + 1;	// ex_end is set one edge after the strobe
			if (rdy < last_c) rdy = last_c;	// one retire per cycle
			exp_cv = (cyc == rdy + 1);
		end
		if (commit_valid !== exp_cv) flag_value("commit_valid", exp_cv, commit_valid);
		if (commit_valid === 1'b1 && mq.size() > 0) begin
			if (commit_pc !== mq[0].pc) flag_value("commit_pc", mq[0].pc, commit_pc);
			if (got_f !== mq[0].f) flag_value("commit_fields", mq[0].f, got_f);
			void'(mq.pop_front());
			last_c = cyc;
		end
		if (stall !== (mq.size() > ENTRIES - 2)) begin
			flag_value("stall", mq.size() > ENTRIES - 2, stall);
		end
		if (stall === 1'b1) stalls++;
		tag_n = tag_m + 1'b1;
		if (regist_tag0 !== tag_m) flag_value("regist_tag0", tag_m, regist_tag0);
		if (regist_tag1 !== tag_n) flag_value("regist_tag1", tag_n, regist_tag1);
	endtask

	task automatic push_entry(input logic [`COMMIT_PC_W-1:0] a, input logic [F_W-1:0] f,
			input int dl);
		mq.push_back(ent_t'{a, f, tag_m, cyc});
		pend.push_back(cmp_t'{tag_m, cyc + 2 + dl});	// the entry waits two edges after the drive
		done_at[tag_m] = -1;
		tag_m = tag_m + 1'b1;
	endtask

	task automatic apply_row(input row_t r);
		logic take0;
		int held;
		clear_inputs();
		if (r.rst) begin
			restart = 1'b1;
			held = 0;
			foreach (mq[i]) begin
				if (mq[i].acc + 2 <= cyc) held++;	// still in registration otherwise
			end
			#5;
			if (flush_count !== held) flag_value("flush_count", held, flush_count);
			mq.delete();
			pend.delete();
			tag_m = '0;
		end else begin
			take0 = r.v0 && !(mq.size() > ENTRIES - 2);
			d0_valid = r.v0;
			d1_valid = r.v1;
			if (r.v0) begin
				pc = r.pc;
				{d0_make_flags, d0_writeback, d0_flags_preg, d0_dest_preg,
					d0_dest_lreg, d0_dest_sysreg, d0_ex_branch} = r.f0;
				{d1_make_flags, d1_writeback, d1_flags_preg, d1_dest_preg,
					d1_dest_lreg, d1_dest_sysreg, d1_ex_branch} = r.f1;
			end
			if (take0) push_entry(r.pc, r.f0, r.dl0);
			if (take0 && r.v1) push_entry(r.pc + `COMMIT_PC_STEP, r.f1, r.dl1);
		end
	endtask

	task automatic issue_completions();
		int perm [4];
		int n;
		int j;
		int t;
		for (int i = 0; i < 4; i++) perm[i] = i;
		for (int i = 3; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			t = perm[i];
			perm[i] = perm[j];
			perm[j] = t;
		end
		n = 0;
		j = 0;
		while (j < pend.size()) begin
			if (n < 4 && pend[j].due <= cyc) begin
				ex_v[perm[n]] = 1'b1;
				ex_t[perm[n]] = pend[j].tag;
				done_at[pend[j].tag] = cyc;
				pend.delete(j);
				n++;
			end else begin
				j++;	// late ones wait for a free port
			end
		end
	endtask

	task automatic step(input row_t r);
		@(negedge iCLOCK);
		cyc++;
		check_outputs();
		apply_row(r);
		issue_completions();
	endtask

	initial begin
		row_t idle;
		int maxd;
		void'($urandom(32'ha980));
		inRESET = 1'b0;
		clear_inputs();
		tag_m = '0;
		foreach (done_at[i]) done_at[i] = -1;
		add_row(0, 0, 1, 1, 32'h0000_1000, 19'h12345, 19'h6789a, 0, 0);
		add_row(0, 0, 1, 0, 32'h0000_2000, 19'h0f0f0, 19'h00000, 3, 0);
		add_row(0, 0, 1, 1, 32'h0000_3000, 19'h7abcd, 19'h13579, 5, 0);	// slot 1 ends first
		add_row(0, 0, 0, 0, 32'h0000_0000, 19'h00000, 19'h00000, 0, 0);
		add_row(0, 0, 1, 1, 32'h0000_4000, 19'h2468a, 19'h55555, 1, 4);
		add_row(0, 0, 1, 1, 32'h0000_5000, 19'h2aaaa, 19'h3cccc, 6, 2);
		add_row(0, 0, 1, 0, 32'h0000_6000, 19'h40001, 19'h00000, 0, 0);
		// late completions fill the ring until stall rises and later pairs are dropped
		add_row(0, 1, 1, 1, 32'h0000_7000, 19'h11111, 19'h22222, 9, 8);
		add_row(0, 0, 1, 1, 32'h0000_7100, 19'h33333, 19'h44444, 8, 9);
		add_row(0, 0, 1, 1, 32'h0000_7200, 19'h5a5a5, 19'h6b6b6, 7, 9);
		add_row(0, 0, 1, 1, 32'h0000_7300, 19'h7c7c7, 19'h0d0d0, 9, 7);
		add_row(0, 0, 1, 1, 32'h0000_7400, 19'h1e1e1, 19'h2f2f2, 2, 2);
		add_row(0, 0, 1, 0, 32'h0000_7500, 19'h30303, 19'h00000, 1, 0);
		add_row(0, 0, 1, 1, 32'h0000_7600, 19'h41414, 19'h52525, 3, 1);
		add_row(0, 1, 1, 1, 32'h0000_8000, 19'h63636, 19'h74747, 20, 20);
		add_row(0, 0, 1, 1, 32'h0000_8100, 19'h05050, 19'h16161, 20, 20);
		add_row(0, 0, 0, 0, 32'h0000_0000, 19'h00000, 19'h00000, 0, 0);
		add_row(1, 0, 0, 0, 32'h0000_0000, 19'h00000, 19'h00000, 0, 0);
		add_row(0, 0, 1, 1, 32'h0000_9000, 19'h27272, 19'h38383, 2, 0);
		add_row(0, 0, 1, 0, 32'h0000_9100, 19'h49494, 19'h00000, 1, 0);
		add_row(0, 0, 1, 1, 32'h0000_9200, 19'h5abab, 19'h6cdcd, 0, 3);
		add_row(0, 0, 0, 0, 32'h0000_0000, 19'h00000, 19'h00000, 0, 0);
		maxd = 0;
		foreach (rows[i]) begin
			if (rows[i].dl0 > maxd) maxd = rows[i].dl0;
			if (rows[i].dl1 > maxd) maxd = rows[i].dl1;
		end
		limit = rows.size() * (ENTRIES + maxd + 4);
		repeat (2) @(negedge iCLOCK);
		inRESET = 1'b1;
		foreach (rows[i]) begin
			if (rows[i].wt) begin
				while (mq.size() > 0) step(idle);
			end
			step(rows[i]);
		end
		while (mq.size() > 0) step(idle);
		repeat (ENTRIES) step(idle);	// nothing more may commit
		if (stalls == 0) begin
			$display("stall never rose while the ring was full");
			other_errs++;
		end
		$display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+include
design/commit_pkg.sv
design/commit_regist.sv
design/commit_entry.sv
design/commit_array.sv
design/commit_retire.sv
design/commit_queue.sv
sim/commit_queue_assertions.sv
sim/commit_queue_tb.sv

//--- run.sh
#!/bin/bash
# build and run the commit queue testbench, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module commit_queue_tb \
	-o commit_queue_sim > build.log 2>&1 || echo "Verification failed: build error" > sim.log
[ -f sim.log ] || ./obj_dir/commit_queue_sim > sim.log 2>&1 \
	|| echo "Verification failed: simulator exit status" >> sim.log
grep -q "Verification passed" sim.log || echo "Verification failed: no result line" >> sim.log
grep -q "Verification failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
	|| { echo "PASS"; exit 0; }
